// ==== logic/riscvPkg.sv ====
package riscvPkg;

    // Datapath widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // Byte address bits 7..2 pick the word
    localparam int MEM_WORDS = 64;
    localparam int MEM_ADDR_W = 6;

    // RV32I major opcodes handled by the datapath
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_t;

    // Encoded as {instruction[30], funct3}
    // so the decoder can take funct3 straight through
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } aluOp_t;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memSize_t;

    typedef enum logic [1:0] {
        ALU       = 2'b00,
        UPPER_IMM = 2'b01,
        PC_NEXT   = 2'b10,
        MEMORY    = 2'b11
    } wbSource_t;

    typedef struct packed {
        logic     read;
        logic     write;
        memSize_t size;
        logic     unsignedLoad;
    } memCtrl_t;

    // Full decode of one instruction
    typedef struct packed {
        aluOp_t    aluOp;
        logic      aluUsesImm;
        logic      regWrite;
        wbSource_t wbSource;
        memCtrl_t  mem;
    } control_t;

    // One register write-back, also the trace port format
    typedef struct packed {
        logic                  enable;
        logic [REG_ADDR_W-1:0] address;
        logic [XLEN-1:0]       data;
    } regWrite_t;

endpackage

// ==== logic/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit import riscvPkg::*; (
    input  logic [31:0] instruction,
    output control_t    control
);

    opcode_t    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = opcode_t'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        // Unknown opcodes keep this and write nothing
        control = '0;
        control.aluOp = ADD;
        control.wbSource = ALU;
        control.mem.size = WORD;

        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b???, LUI}: begin
                control.regWrite = 1'b1;
                control.wbSource = UPPER_IMM;
            end
            {7'b???????, 3'b???, JAL}: begin
                // Only the link value here
                control.regWrite = 1'b1;
                control.wbSource = PC_NEXT;
            end
            {7'b???????, 3'b???, LOAD}: begin
                control.aluUsesImm = 1'b1;
                control.regWrite = 1'b1;
                control.wbSource = MEMORY;
                control.mem.read = 1'b1;
                control.mem.size = memSize_t'(funct3[1:0]);
                control.mem.unsignedLoad = funct3[2];
            end
            {7'b???????, 3'b???, STORE}: begin
                control.aluUsesImm = 1'b1;
                control.mem.write = 1'b1;
                control.mem.size = memSize_t'(funct3[1:0]);
            end
            {7'b0100000, 3'b101, OP_IMM}: begin
                // SRAI
                control.aluOp = SRA;
                control.aluUsesImm = 1'b1;
                control.regWrite = 1'b1;
            end
            {7'b???????, 3'b???, OP_IMM}: begin
                // Bit 30 is immediate data here
                control.aluOp = aluOp_t'({1'b0, funct3});
                control.aluUsesImm = 1'b1;
                control.regWrite = 1'b1;
            end
            {7'b0100000, 3'b000, OP}: begin
                control.aluOp = SUB;
                control.regWrite = 1'b1;
            end
            {7'b0100000, 3'b101, OP}: begin
                control.aluOp = SRA;
                control.regWrite = 1'b1;
            end
            {7'b???????, 3'b???, OP}: begin
                control.aluOp = aluOp_t'({1'b0, funct3});
                control.regWrite = 1'b1;
            end
            default: begin
                control.regWrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/immediateExtractor.sv ====
`timescale 1ns/100ps

module immediateExtractor import riscvPkg::*; (
    input  logic [31:0] instruction,
    output logic [31:0] immediate
);

    opcode_t opcode;

    assign opcode = opcode_t'(instruction[6:0]);

    always_comb begin
        case (opcode)
            // I format with shift amounts in the low five bits
            OP_IMM, LOAD: begin
                immediate = {{20{instruction[31]}}, instruction[31:20]};
            end
            // S format is split around rd
            STORE: begin
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            default: begin
                immediate = 32'h0;
            end
        endcase
    end

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/100ps

module registerFile import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [REG_ADDR_W-1:0] rs1Address,
    input  logic [REG_ADDR_W-1:0] rs2Address,
    input  regWrite_t             write,
    output logic [XLEN-1:0]       rs1Data,
    output logic [XLEN-1:0]       rs2Data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && write.address != '0) begin
            // x0 never takes a write and stays zero from reset
            regs[write.address] <= write.data;
        end
    end

    // Combinational reads see the previous instruction's write
    assign rs1Data = regs[rs1Address];
    assign rs2Data = regs[rs2Address];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu import riscvPkg::*; (
    input  aluOp_t          op,
    input  logic [XLEN-1:0] left,
    input  logic [XLEN-1:0] right,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = right[4:0];

    always_comb begin
        case (op)
            ADD:  result = left + right;
            SUB:  result = left - right;
            SLL:  result = left << shamt;
            SLT:  result = {{(XLEN-1){1'b0}}, $signed(left) < $signed(right)};
            SLTU: result = {{(XLEN-1){1'b0}}, left < right};
            XOR:  result = left ^ right;
            SRL:  result = left >> shamt;
            // Arithmetic shift keeps the sign
            SRA:  result = $unsigned($signed(left) >>> shamt);
            OR:   result = left | right;
            AND:  result = left & right;
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== logic/dataMemory.sv ====
`timescale 1ns/100ps

module dataMemory import riscvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  memCtrl_t        ctrl,
    input  logic [XLEN-1:0] address,
    input  logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData
);

    logic [XLEN-1:0]       mem [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] wordIndex;
    logic [1:0]            byteLane;
    logic [XLEN-1:0]       word;
    logic [7:0]            loadByte;
    logic [15:0]           loadHalf;

    // Upper address bits wrap and misaligned accesses stay in the word
    assign wordIndex = address[MEM_ADDR_W+1:2];
    assign byteLane = address[1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.write) begin
            case (ctrl.size)
                BYTE: mem[wordIndex][8*byteLane +: 8] <= writeData[7:0];
                HALF: mem[wordIndex][16*address[1] +: 16] <= writeData[15:0];
                default: begin
                    mem[wordIndex] <= writeData;
                end
            endcase
        end
    end

    assign word = mem[wordIndex];
    assign loadByte = word[8*byteLane +: 8];
    // Halfword lane from bit 1 only
    assign loadHalf = word[16*address[1] +: 16];

    always_comb begin
        if (!ctrl.read) begin
            readData = '0;
        end else begin
            case (ctrl.size)
                BYTE: begin
                    readData = {{24{loadByte[7] & ~ctrl.unsignedLoad}}, loadByte};
                end
                HALF: begin
                    readData = {{16{loadHalf[15] & ~ctrl.unsignedLoad}}, loadHalf};
                end
                default: begin
                    readData = word;
                end
            endcase
        end
    end

endmodule

// ==== logic/singleInstruction.sv ====
`timescale 1ns/100ps

module singleInstruction import riscvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            instrValid,
    input  logic [31:0]     instruction,
    input  logic [XLEN-1:0] pcNext,
    output regWrite_t       writeback
);

    logic [REG_ADDR_W-1:0] rdAddr;
    logic [REG_ADDR_W-1:0] rs1Addr;
    logic [REG_ADDR_W-1:0] rs2Addr;
    control_t              control;
    memCtrl_t              memCtrl;
    logic [XLEN-1:0]       immediate;
    logic [XLEN-1:0]       rs1Data;
    logic [XLEN-1:0]       rs2Data;
    logic [XLEN-1:0]       aluRight;
    logic [XLEN-1:0]       aluResult;
    logic [XLEN-1:0]       loadData;
    logic [XLEN-1:0]       wbData;

    // Register fields
    assign {rs2Addr, rs1Addr} = instruction[24:15];
    assign rdAddr = instruction[11:7];

    controlUnit decoder (
        .instruction (instruction),
        .control     (control)
    );

    immediateExtractor immGen (
        .instruction (instruction),
        .immediate   (immediate)
    );

    registerFile regFile (
        .clk        (clk),
        .rstN       (rstN),
        .rs1Address (rs1Addr),
        .rs2Address (rs2Addr),
        .write      (writeback),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data)
    );

    assign aluRight = control.aluUsesImm ? immediate : rs2Data;

    alu mainAlu (
        .op     (control.aluOp),
        .left   (rs1Data),
        .right  (aluRight),
        .result (aluResult)
    );

    // Stores only land when the instruction is valid
    always_comb begin
        memCtrl = control.mem;
        memCtrl.write = control.mem.write & instrValid;
    end

    dataMemory dataMem (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (memCtrl),
        .address   (aluResult),
        .writeData (rs2Data),
        .readData  (loadData)
    );

    always_comb begin
        case (control.wbSource)
            UPPER_IMM: wbData = {instruction[31:12], 12'h000};
            PC_NEXT:   wbData = pcNext;
            MEMORY:    wbData = loadData;
            default: begin
                wbData = aluResult;
            end
        endcase
    end

    assign writeback.enable = control.regWrite & instrValid;
    assign writeback.address = rdAddr;
    assign writeback.data = wbData;

endmodule

// ==== bench/singleInstructionTb.sv ====
`timescale 1ns/100ps

module singleInstructionTb import riscvPkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;

    // funct3 of ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    localparam logic [2:0] IMM_FUNCT3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    // {bit 30, funct3} of the ten R-type operations
    localparam logic [3:0] R_OPS [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6,
                                          4'h7};

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pcNext;
        logic        valid;
        regWrite_t   expected;
    } entry_t;

    logic            clk = 1'b0;
    logic            rstN;
    logic            instrValid;
    logic [31:0]     instruction;
    logic [XLEN-1:0] pcNext;
    regWrite_t       writeback;

    entry_t      stimTable [$];
    logic        tableReady = 1'b0;
    logic [31:0] lcgState = 32'hda93;
    logic [31:0] pcCounter = 32'h0000_1000;
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [MEM_WORDS];
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    singleInstruction DUT (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instruction (instruction),
        .pcNext      (pcNext),
        .writeback   (writeback)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] upper, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {upper, rd, opc};
    endfunction

    function automatic logic [31:0] modelAlu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] modelLoad(input logic [31:0] addr, input logic [2:0] f3);
        logic [31:0] word;
        logic [7:0]  lowByte;
        logic [15:0] half;
        word = modelMem[addr[7:2]];
        lowByte = 8'(word >> {addr[1:0], 3'b000});
        half = addr[1] ? word[31:16] : word[15:0];
        case (f3)
            3'd0: return {{24{lowByte[7]}}, lowByte};
            3'd1: return {{16{half[15]}}, half};
            3'd4: return {24'h0, lowByte};
            3'd5: return {16'h0, half};
            default: return word;
        endcase
    endfunction

    task automatic storeModel(input logic [31:0] addr, input logic [2:0] f3,
                              input logic [31:0] data);
        logic [5:0] idx;
        idx = addr[7:2];
        case (f3[1:0])
            2'd0: modelMem[idx][{addr[1:0], 3'b000} +: 8] = data[7:0];
            2'd1: modelMem[idx][{addr[1], 4'b0000} +: 16] = data[15:0];
            default: modelMem[idx] = data;
        endcase
    endtask

    // Reference model for one instruction on its own register and memory copies
    task automatic modelStep(input entry_t e, output regWrite_t expected);
        logic [31:0] left;
        logic [31:0] right;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] result;
        logic [2:0]  f3;
        left = modelRegs[e.instr[19:15]];
        right = modelRegs[e.instr[24:20]];
        immI = {{20{e.instr[31]}}, e.instr[31:20]};
        immS = {{20{e.instr[31]}}, e.instr[31:25], e.instr[11:7]};
        f3 = e.instr[14:12];
        result = '0;
        expected = '0;
        expected.address = e.instr[11:7];
        case (e.instr[6:0])
            LUI: begin
                expected.enable = 1'b1;
                result = {e.instr[31:12], 12'h000};
            end
            JAL: begin
                expected.enable = 1'b1;
                result = e.pcNext;
            end
            OP_IMM: begin
                // Bit 30 only selects SRAI and is immediate data elsewhere
                expected.enable = 1'b1;
                result = modelAlu(f3, e.instr[30] && f3 == 3'd5, left, immI);
            end
            OP: begin
                expected.enable = 1'b1;
                result = modelAlu(f3, e.instr[30], left, right);
            end
            LOAD: begin
                expected.enable = 1'b1;
                result = modelLoad(left + immI, f3);
            end
            STORE: begin
                if (e.valid) begin
                    storeModel(left + immS, f3, right);
                end
            end
            default: result = '0;
        endcase
        expected.enable = expected.enable & e.valid;
        expected.data = result;
        if (expected.enable && expected.address != '0) begin
            modelRegs[expected.address] = result;
        end
    endtask

    task automatic addEntry(input logic [31:0] instr, input logic valid);
        entry_t e;
        pcCounter = pcCounter + 32'd4;
        e.instr = instr;
        e.pcNext = pcCounter;
        e.valid = valid;
        e.expected = '0;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        // Held back and then taken right after reset
        addEntry(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b0);
        addEntry(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1);
        for (int r = 1; r <= 6; r++) begin
            rnd = nextRandom();
            addEntry(encU(rnd[31:12], 5'(r), LUI), 1'b1);
            addEntry(encI(rnd[11:0], 5'(r), 3'd0, 5'(r), OP_IMM), 1'b1);
        end
        // Fixed pair so SLT and SLTU disagree
        addEntry(encI(12'h800, 5'd0, 3'd0, 5'd7, OP_IMM), 1'b1);
        addEntry(encI(12'h005, 5'd0, 3'd0, 5'd8, OP_IMM), 1'b1);
        for (int k = 0; k < 18; k++) begin
            rnd = nextRandom();
            imm = rnd[11:0];
            if (k % 9 >= 6) begin
                imm[11:5] = (k % 9 == 8) ? 7'h20 : 7'h00;
            end
            addEntry(encI(imm, 5'(1 + k % 8), IMM_FUNCT3[k % 9], 5'(9 + k % 7), OP_IMM), 1'b1);
        end
        addEntry(encI(12'h7ff, 5'd1, 3'd0, 5'd0, OP_IMM), 1'b1);
        addEntry(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd16), 1'b1);
        for (int k = 0; k < 20; k++) begin
            rs1 = 5'd7;
            rs2 = 5'd8;
            if (k >= 10) begin
                rnd = nextRandom();
                rs1 = 5'(1 + rnd[2:0]);
                rs2 = 5'(1 + rnd[5:3]);
            end
            addEntry(encR({1'b0, R_OPS[k % 10][3], 5'b0}, rs2, rs1, R_OPS[k % 10][2:0],
                          5'(16 + k % 10)), 1'b1);
        end
        rnd = nextRandom();
        addEntry(encU(rnd[31:12], 5'd27, LUI), 1'b1);
        addEntry(encU(20'h00000, 5'd28, JAL), 1'b1);
        // Stores around base 0x40 and then loads of the merged bytes
        addEntry(encI(12'h040, 5'd0, 3'd0, 5'd29, OP_IMM), 1'b1);
        addEntry(encS(12'd0, 5'd1, 5'd29, 3'd2), 1'b1);
        addEntry(encS(12'd2, 5'd2, 5'd29, 3'd1), 1'b1);
        addEntry(encS(12'd1, 5'd3, 5'd29, 3'd0), 1'b1);
        addEntry(encS(12'd8, 5'd7, 5'd29, 3'd2), 1'b1);
        addEntry(encI(12'd0, 5'd29, 3'd2, 5'd9, LOAD), 1'b1);
        addEntry(encI(12'd2, 5'd29, 3'd1, 5'd10, LOAD), 1'b1);
        addEntry(encI(12'd2, 5'd29, 3'd5, 5'd11, LOAD), 1'b1);
        addEntry(encI(12'd1, 5'd29, 3'd0, 5'd12, LOAD), 1'b1);
        addEntry(encI(12'd1, 5'd29, 3'd4, 5'd13, LOAD), 1'b1);
        addEntry(encI(12'd3, 5'd29, 3'd0, 5'd14, LOAD), 1'b1);
        addEntry(encI(12'd9, 5'd29, 3'd0, 5'd15, LOAD), 1'b1);
        addEntry(encI(12'd9, 5'd29, 3'd4, 5'd16, LOAD), 1'b1);
        addEntry(encI(12'd8, 5'd29, 3'd1, 5'd17, LOAD), 1'b1);
        addEntry(encI(12'd8, 5'd29, 3'd5, 5'd18, LOAD), 1'b1);
        // Not valid so neither may land
        addEntry(encS(12'd0, 5'd8, 5'd29, 3'd2), 1'b0);
        addEntry(encI(12'h123, 5'd0, 3'd0, 5'd9, OP_IMM), 1'b0);
        addEntry(encI(12'd0, 5'd29, 3'd2, 5'd19, LOAD), 1'b1);
        addEntry(encR(7'h00, 5'd0, 5'd9, 3'd0, 5'd20), 1'b1);
    endtask

    task automatic compareWriteback(input regWrite_t got, input regWrite_t expected);
        if (got.enable !== expected.enable) begin
            $display("[ERROR] writeback.enable got %h expected %h", got.enable, expected.enable);
            errorCount++;
        end
        if (expected.enable && got.address !== expected.address) begin
            $display("[ERROR] writeback.address got %h expected %h", got.address,
                     expected.address);
            errorCount++;
        end
        if (expected.enable && got.data !== expected.data) begin
            $display("[ERROR] writeback.data got %h expected %h", got.data, expected.data);
            errorCount++;
        end
    endtask

    task automatic compareData(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    initial begin : watchdog
        int unsigned limitNs;
        wait (tableReady);
        limitNs = (stimTable.size() + RESET_CYCLES + 10) * CLK_PERIOD;
        #(limitNs);
        $display("Timeout: the table was not finished after %0d ns", limitNs);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        entry_t      entry;
        regWrite_t   expected;
        logic [31:0] loadAddr;
        logic        isLoad;
        int          errorsBefore;
        rstN <= 1'b0;
        instrValid <= 1'b0;
        instruction <= '0;
        pcNext <= '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < stimTable.size(); i++) begin
            entry = stimTable[i];
            isLoad = entry.valid && entry.instr[6:0] == LOAD;
            // Address taken before the step since rd may overwrite rs1
            loadAddr = modelRegs[entry.instr[19:15]] + {{20{entry.instr[31]}}, entry.instr[31:20]};
            modelStep(entry, expected);
            entry.expected = expected;
            stimTable[i] = entry;
            @(posedge clk);
            instrValid <= entry.valid;
            instruction <= entry.instr;
            pcNext <= entry.pcNext;
            @(negedge clk);
            errorsBefore = errorCount;
            compareWriteback(writeback, entry.expected);
            if (isLoad) begin
                compareData("load data", writeback.data, modelLoad(loadAddr, entry.instr[14:12]));
            end
            if (errorCount == errorsBefore) begin
                passCount++;
            end else begin
                failCount++;
            end
            $display("Entry %0d instr %08h valid %0b: %s", i, entry.instr, entry.valid,
                     (errorCount == errorsBefore) ? "ok" : "mismatch");
        end
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        $display("Entries passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/riscvPkg.sv
logic/controlUnit.sv
logic/immediateExtractor.sv
logic/registerFile.sv
logic/alu.sv
logic/dataMemory.sv
logic/singleInstruction.sv
bench/singleInstructionTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module singleInstructionTb -f filelist.f -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "Everything OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }
